/* iq_gain.f */
rtl/iq_gain_pkg.sv
rtl/gain_mult.sv
rtl/conv_round.sv
rtl/iq_gain_top.sv
dv/iq_gain_tb.sv

/* Makefile */
# Verilator build and run for the IQ gain stage

TOP := iq_gain_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f iq_gain.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f iq_gain.f --top-module $(TOP)
	verilator --lint-only --assert rtl/iq_gain_pkg.sv rtl/gain_mult.sv \
		rtl/conv_round.sv rtl/iq_gain_top.sv --top-module iq_gain_top

clean:
	rm -rf obj_dir

/* dv/iq_gain_vectors.txt */
// columns: op gain mode sample0 sample1 expected0 expected1, all hex
// op 0 load gain, 1 sample, 2 load and sample in one cycle, 3 sample back to back
// mode 0 rounds ties to even, 1 to odd; unused fields are zero
// non-tie rounding at the reset gain
1 0000 0 000C00 FFF400 0003 FFFD
1 0000 0 000D00 FFF300 0003 FFFD
1 0000 1 000F00 FFF100 0004 FFFC
1 0000 0 0001FF 000201 0000 0001
1 0000 1 FFFE01 FFFDFF 0000 FFFF
1 0000 0 7FFFFF 800000 2000 E000
// ties, positive, negative and around zero
1 0000 0 000E00 000A00 0004 0002
1 0000 1 000E00 000A00 0003 0003
1 0000 0 FFF200 FFF600 FFFC FFFE
1 0000 1 FFF200 FFF600 FFFD FFFD
1 0000 0 000200 FFFE00 0000 0000
1 0000 1 000200 FFFE00 0001 FFFF
// load in the sample cycle keeps the old gain, the next sample sees the new one
2 C000 0 000E00 000F00 0004 0004
3 0000 0 000E00 000F00 FFFC FFFC
1 0000 1 000E00 FFF300 FFFD 0003
1 0000 1 FFF200 000D00 0003 FFFD
// small gain
0 0100 0 000000 000000 0000 0000
1 0000 0 018000 028000 0002 0002
1 0000 1 018000 028000 0001 0003
1 0000 0 00C000 FF4000 0001 FFFF
3 0000 1 7FFFFF 004000 0080 0000
// near full-scale gain
0 7FFF 0 000000 000000 0000 0000
1 0000 0 000400 FFFC00 0002 FFFE
1 0000 1 000200 FFFE00 0001 FFFF
2 2000 0 000400 000200 0002 0001
3 0000 0 000C00 001400 0002 0002
3 0000 1 000C00 001400 0001 0003
3 0000 0 FFF400 FFEC00 FFFE FFFE
3 0000 1 FFF400 FFEC00 FFFF FFFD
1 0000 0 000400 000A00 0000 0001
1 0000 1 000400 000A00 0001 0001
// back to the reset gain, streaming with the mode changing per sample
0 4000 0 000000 000000 0000 0000
3 0000 1 000E00 000200 0003 0001
3 0000 0 000E00 000200 0004 0000
1 0000 1 FFF600 FFFE00 FFFD FFFF
3 0000 0 FFF600 FFFE00 FFFE 0000
3 0000 1 0001FF 000201 0000 0001
1 0000 0 7FFFFF 800000 2000 E000
3 0000 1 000A00 FFF200 0003 FFFD
3 0000 0 000A00 FFF200 0002 FFFC
1 0000 1 001000 FFF000 0004 FFFC
3 0000 0 123400 FEDC00 048D FFB7
3 0000 1 000600 FFFA00 0001 FFFF
3 0000 0 000600 FFFA00 0002 FFFE

/* dv/iq_gain_tb.sv */
// iq_gain_tb: vector-driven testbench for the two-channel gain and convergent rounding stage
`timescale 1ns/1ps

module iq_gain_tb;

    // command codes of the vectors file
    localparam int OP_LOAD        = 0;
    localparam int OP_SAMPLE      = 1;
    localparam int OP_LOAD_SAMPLE = 2;
    localparam int OP_SAMPLE_B2B  = 3;
    localparam int MAX_CMDS       = 256;

    logic                     clk_i;
    logic                     rstn_i;
    logic                     gain_load_i;
    iq_gain_pkg::gain_t       gain_i;
    logic                     valid_i;
    iq_gain_pkg::sample_in_t  data_i [iq_gain_pkg::NUM_CH];
    iq_gain_pkg::round_mode_e mode_i;
    logic                     valid_o;
    iq_gain_pkg::sample_out_t data_o [iq_gain_pkg::NUM_CH];

    // command table filled from the vectors file
    logic [31:0] v_op   [MAX_CMDS];
    logic [31:0] v_gain [MAX_CMDS];
    logic [31:0] v_mode [MAX_CMDS];
    logic [31:0] v_s0   [MAX_CMDS];
    logic [31:0] v_s1   [MAX_CMDS];
    logic [31:0] v_e0   [MAX_CMDS];
    logic [31:0] v_e1   [MAX_CMDS];
    int          n_cmds;

    // expected results with the cycle each one is due
    int                       exp_due [$];
    iq_gain_pkg::sample_out_t exp_ch0 [$];
    iq_gain_pkg::sample_out_t exp_ch1 [$];

    int          cycle;
    int          cycle_limit;
    logic [31:0] rng_state;

    iq_gain_top UUT (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .gain_load_i (gain_load_i),
        .gain_i      (gain_i),
        .valid_i     (valid_i),
        .data_i      (data_i),
        .mode_i      (mode_i),
        .valid_o     (valid_o),
        .data_o      (data_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_valid(input logic exp);
        if (valid_o !== exp) begin
            $display("ERROR valid_o expected %h actual %h", exp, valid_o);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_sample(input iq_gain_pkg::sample_out_t exp, input int ch);
        if (data_o[ch] !== exp) begin
            $display("ERROR data_o[%0d] expected %h actual %h", ch, exp, data_o[ch]);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("dv/iq_gain_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file");
            $display("test failed");
            $fatal(1);
        end
        n_cmds = 0;
        while (!$feof(fd) && n_cmds < MAX_CMDS) begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%h %h %h %h %h %h %h", v_op[n_cmds], v_gain[n_cmds],
                          v_mode[n_cmds], v_s0[n_cmds], v_s1[n_cmds],
                          v_e0[n_cmds], v_e1[n_cmds]);
            // comment and blank lines do not parse into seven fields
            if (cnt == 7) begin
                n_cmds++;
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            valid_i     <= 1'b0;
            gain_load_i <= 1'b0;
        end
    endtask

    // the result of a sample driven now is due four cycles after the cycle it is seen in
    task automatic issue_cmd(input int idx, input logic do_load, input logic do_sample);
        @(posedge clk_i);
        gain_load_i <= do_load;
        gain_i      <= iq_gain_pkg::gain_t'(v_gain[idx]);
        valid_i     <= do_sample;
        mode_i      <= iq_gain_pkg::round_mode_e'(v_mode[idx][0]);
        data_i[0]   <= iq_gain_pkg::sample_in_t'(v_s0[idx]);
        data_i[1]   <= iq_gain_pkg::sample_in_t'(v_s1[idx]);
        if (do_sample) begin
            exp_due.push_back(cycle + 1 + 4);
            exp_ch0.push_back(iq_gain_pkg::sample_out_t'(v_e0[idx]));
            exp_ch1.push_back(iq_gain_pkg::sample_out_t'(v_e1[idx]));
        end
    endtask

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $fatal(1);
        end
    end

    // outputs are checked mid-cycle, well away from the driving edge
    always @(negedge clk_i) begin
        if (valid_o === 1'b1 && exp_due.size() == 0) begin
            $display("valid_o went high with no result expected");
            $display("test failed");
            $fatal(1);
        end
        check_valid(exp_due.size() != 0 && exp_due[0] == cycle);
        if (valid_o === 1'b1) begin
            check_sample(exp_ch0[0], 0);
            check_sample(exp_ch1[0], 1);
            void'(exp_due.pop_front());
            void'(exp_ch0.pop_front());
            void'(exp_ch1.pop_front());
        end
    end

    initial begin
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        gain_load_i = 1'b0;
        gain_i      = '0;
        valid_i     = 1'b0;
        mode_i      = iq_gain_pkg::ROUND_EVEN;
        data_i[0]   = '0;
        data_i[1]   = '0;
        cycle       = 0;
        cycle_limit = 1000;
        rng_state   = 32'h2587df32;

        read_vectors();
        cycle_limit = n_cmds * 5 + 8 + 4 + 20;

        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;

        for (int i = 0; i < n_cmds; i++) begin
            rng_state = xorshift32(rng_state);
            if (v_op[i] != OP_SAMPLE_B2B) begin
                idle_cycles(int'(rng_state[1:0]));
            end
            case (int'(v_op[i]))
                OP_LOAD:                  issue_cmd(i, 1'b1, 1'b0);
                OP_LOAD_SAMPLE:           issue_cmd(i, 1'b1, 1'b1);
                OP_SAMPLE, OP_SAMPLE_B2B: issue_cmd(i, 1'b0, 1'b1);
                default: begin
                    $display("unknown command %0d in the vectors file", v_op[i]);
                    $display("test failed");
                    $fatal(1);
                end
            endcase
        end

        // the last result is due four cycles after its issue edge and is
        // checked on the falling edge before the fifth edge
        idle_cycles(5);

        if (exp_due.size() != 0) begin
            $display("results still outstanding at the end of the run");
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* rtl/iq_gain_top.sv */
// iq_gain_top: two-channel gain stage, shared gain multiply followed by convergent rounding
`timescale 1ns/1ps

module iq_gain_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,

    // gain load, one-cycle strobe
    input  logic                      gain_load_i,
    input  iq_gain_pkg::gain_t        gain_i,

    // one sample per channel on every valid cycle
    input  logic                      valid_i,
    input  iq_gain_pkg::sample_in_t   data_i [iq_gain_pkg::NUM_CH],
    input  iq_gain_pkg::round_mode_e  mode_i,

    // rounded results, four cycles after valid_i
    output logic                      valid_o,
    output iq_gain_pkg::sample_out_t  data_o [iq_gain_pkg::NUM_CH]
);

    // products between the multiplier and the rounder
    logic                     prod_valid;
    iq_gain_pkg::product_t    prod_data [iq_gain_pkg::NUM_CH];
    iq_gain_pkg::round_mode_e prod_mode;

    gain_mult u_gain_mult (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .gain_load_i (gain_load_i),
        .gain_i      (gain_i),
        .valid_i     (valid_i),
        .data_i      (data_i),
        .mode_i      (mode_i),
        .valid_o     (prod_valid),
        .prod_o      (prod_data),
        .mode_o      (prod_mode)
    );

    conv_round u_conv_round (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .valid_i (prod_valid),
        .prod_i  (prod_data),
        .mode_i  (prod_mode),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

endmodule

/* rtl/conv_round.sv */
// conv_round: two-stage convergent rounding of every channel from product width to output width
`timescale 1ns/1ps

module conv_round (
    input  logic                      clk_i,
    input  logic                      rstn_i,

    // full-width products with the rounding mode of that sample
    input  logic                      valid_i,
    input  iq_gain_pkg::product_t     prod_i [iq_gain_pkg::NUM_CH],
    input  iq_gain_pkg::round_mode_e  mode_i,

    // rounded results, two cycles after valid_i
    output logic                      valid_o,
    output iq_gain_pkg::sample_out_t  data_o [iq_gain_pkg::NUM_CH]
);

    // rounding constant picked by the mode of the incoming sample
    iq_gain_pkg::product_t round_c;

    // mode travels with its sample into stage two
    iq_gain_pkg::round_mode_e mode_q;

    logic [1:0] valid_d;

    // round-half-to-even adds exactly a half, so a tie leaves all zeros below the cut
    // round-half-to-odd adds one LSB less, so a tie leaves all ones there instead
    assign round_c = (mode_i == iq_gain_pkg::ROUND_ODD) ? iq_gain_pkg::RND_HALF_M1
                                                        : iq_gain_pkg::RND_HALF;

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            mode_q <= mode_i;
        end
    end

    for (genvar ch = 0; ch < iq_gain_pkg::NUM_CH; ch++) begin : g_ch
        iq_gain_pkg::product_t      sum_c;
        logic                       tie_c;
        iq_gain_pkg::sample_out_t   sum_hi_q;
        logic                       tie_q;

        // the product never reaches the top bit, so this sum cannot overflow
        assign sum_c = prod_i[ch] + round_c;

        // exact-half fraction shows up as a fixed pattern in the dropped bits
        assign tie_c = (mode_i == iq_gain_pkg::ROUND_ODD) ?
                       (&sum_c[iq_gain_pkg::SHIFT-1:0]) :
                       (~|sum_c[iq_gain_pkg::SHIFT-1:0]);

        // stage one keeps only the bits that survive plus the tie flag
        always_ff @(posedge clk_i) begin
            if (valid_i) begin
                sum_hi_q <= sum_c[iq_gain_pkg::PROD_W-1:iq_gain_pkg::SHIFT];
                tie_q    <= tie_c;
            end
        end

        // stage two, on a tie the LSB is forced to the parity the mode asks for
        always_ff @(posedge clk_i) begin
            if (valid_d[0]) begin
                if (tie_q) begin
                    data_o[ch] <= {sum_hi_q[iq_gain_pkg::OUT_W-1:1],
                                   (mode_q == iq_gain_pkg::ROUND_ODD)};
                end else begin
                    data_o[ch] <= sum_hi_q;
                end
            end
        end

        // a result marked valid must be fully defined
        a_data_known: assert property (
            @(posedge clk_i) disable iff (!rstn_i)
                valid_o |-> !$isunknown(data_o[ch])
        ) else $error("conv_round data_o[%0d] has unknown bits while valid", ch);
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_d <= '0;
        end else begin
            valid_d <= {valid_d[0], valid_i};
        end
    end

    assign valid_o = valid_d[1];

    property p_valid_latency;
        @(posedge clk_i) disable iff (!rstn_i)
            ($past(rstn_i, 1) && $past(rstn_i, 2)) |-> (valid_o == $past(valid_i, 2));
    endproperty

    a_valid_latency: assert property (p_valid_latency)
        else $error("conv_round valid_o does not follow valid_i by two cycles");

endmodule

/* rtl/gain_mult.sv */
// gain_mult: shared loadable gain and a two-stage signed multiply for every channel
`timescale 1ns/1ps

module gain_mult (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    // gain load, one-cycle strobe
    input  logic                     gain_load_i,
    input  iq_gain_pkg::gain_t       gain_i,

    // incoming samples with their rounding mode
    input  logic                     valid_i,
    input  iq_gain_pkg::sample_in_t  data_i [iq_gain_pkg::NUM_CH],
    input  iq_gain_pkg::round_mode_e mode_i,

    // full-width products, two cycles after valid_i
    output logic                     valid_o,
    output iq_gain_pkg::product_t    prod_o [iq_gain_pkg::NUM_CH],
    output iq_gain_pkg::round_mode_e mode_o
);

    // gain currently applied to new samples
    iq_gain_pkg::gain_t gain_q;

    // stage one holds the sample, the gain it sees and its mode
    iq_gain_pkg::sample_in_t  s1_data [iq_gain_pkg::NUM_CH];
    iq_gain_pkg::gain_t       s1_gain;
    iq_gain_pkg::round_mode_e s1_mode;

    // valid pipeline, bit 0 is stage one and bit 1 is stage two
    logic [1:0] valid_d;

    // a sample issued in the load cycle still captures the old gain below,
    // since gain_q only changes at the end of that cycle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            gain_q <= iq_gain_pkg::GAIN_RESET;
        end else if (gain_load_i) begin
            gain_q <= gain_i;
        end
    end

    // stage one, capture operands
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            for (int ch = 0; ch < iq_gain_pkg::NUM_CH; ch++) begin
                s1_data[ch] <= data_i[ch];
            end
            s1_gain <= gain_q;
            s1_mode <= mode_i;
        end
    end

    // stage two, signed multiply on sign-extended operands
    // the product of a 24-bit and a 16-bit signed value always fits in 40 bits
    always_ff @(posedge clk_i) begin
        if (valid_d[0]) begin
            for (int ch = 0; ch < iq_gain_pkg::NUM_CH; ch++) begin
                prod_o[ch] <= iq_gain_pkg::product_t'(s1_data[ch])
                            * iq_gain_pkg::product_t'(s1_gain);
            end
            mode_o <= s1_mode;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_d <= '0;
        end else begin
            valid_d <= {valid_d[0], valid_i};
        end
    end

    assign valid_o = valid_d[1];

    // once two clean cycles have passed since reset, every product appears
    // exactly two cycles after its sample
    property p_valid_latency;
        @(posedge clk_i) disable iff (!rstn_i)
            ($past(rstn_i, 1) && $past(rstn_i, 2)) |-> (valid_o == $past(valid_i, 2));
    endproperty

    a_valid_latency: assert property (p_valid_latency)
        else $error("gain_mult valid_o does not follow valid_i by two cycles");

endmodule

/* rtl/iq_gain_pkg.sv */
// iq_gain_pkg: shared widths, sample types, rounding mode and reset gain of the IQ gain stage
package iq_gain_pkg;

    // one channel each for I and Q
    localparam int NUM_CH = 2;

    localparam int IN_W   = 24;
    localparam int GAIN_W = 16;
    localparam int PROD_W = IN_W + GAIN_W;
    localparam int OUT_W  = 16;

    // fraction bits dropped when the product is rounded to the output width
    localparam int SHIFT = PROD_W - OUT_W;

    typedef logic signed [IN_W-1:0]   sample_in_t;
    typedef logic signed [GAIN_W-1:0] gain_t;
    typedef logic signed [PROD_W-1:0] product_t;
    typedef logic signed [OUT_W-1:0]  sample_out_t;

    // tie handling of the convergent rounder, carried with every sample
    typedef enum logic {
        ROUND_EVEN = 1'b0,
        ROUND_ODD  = 1'b1
    } round_mode_e;

    // half of one output LSB, seen at product scale
    localparam product_t RND_HALF = product_t'(1) << (SHIFT - 1);

    // one product LSB short of a half, used for round-half-to-odd
    localparam product_t RND_HALF_M1 = RND_HALF - product_t'(1);

    // gain after reset, half scale when the gain is read as Q1.15
    localparam gain_t GAIN_RESET = 16'h4000;

endpackage
